/* common/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and instruction widths
`define CPU_DATA_W     16
`define CPU_INSTR_W    32

// Register bank size, r0 and r1 double as port registers
`define CPU_NUM_REGS   8

// Program store depth
`define CPU_MEM_DEPTH  32

// Opcode values for the integer ALU
`define CPU_OP_AND     4'd3
`define CPU_OP_OR      4'd4
`define CPU_OP_XOR     4'd5
`define CPU_OP_GT      4'd6  // Unsigned a > b
`define CPU_OP_LT      4'd7  // Unsigned a < b
`define CPU_OP_MOV     4'd9  // Pass a

// Opcodes 0..2 were the half-precision ops
// Those now fall through to a zero result, as do 8 and 10..15

`endif

/* common/cpu_pkg.sv */
`include "cpu_defs.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0] data_t;
  typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;
  typedef logic [$clog2(`CPU_MEM_DEPTH)-1:0] pc_t;

  // Any other 4-bit value is an unsupported opcode
  typedef enum logic [3:0] {
    OP_AND = `CPU_OP_AND,
    OP_OR  = `CPU_OP_OR,
    OP_XOR = `CPU_OP_XOR,
    OP_GT  = `CPU_OP_GT,
    OP_LT  = `CPU_OP_LT,
    OP_MOV = `CPU_OP_MOV
  } opcode_e;

  // Instruction word, opcode in the top nibble
  typedef struct packed {
    opcode_e                   op;
    reg_idx_t                  rd;    // Destination
    reg_idx_t                  ra;    // Operand A
    reg_idx_t                  rb;    // Operand B
    logic [`CPU_INSTR_W-14:0]  rsvd;  // Ignored
  } instr_t;

  typedef struct packed {
    logic    valid;
    instr_t  instr;
  } load_req_t;

  // Instruction register contents
  typedef struct packed {
    logic    valid;
    instr_t  instr;
  } exec_t;

  typedef enum logic [1:0] {IDLE, RUN, DRAIN} seq_state_e;

endpackage

/* datapath/alu.sv */
`timescale 1ns/1ps

module alu (
  input  cpu_pkg::opcode_e  op,
  input  cpu_pkg::data_t    a,
  input  cpu_pkg::data_t    b,
  output cpu_pkg::data_t    result
);

  logic a_gt_b;
  logic a_lt_b;

  // Compares are unsigned
  assign a_gt_b = (a > b);
  assign a_lt_b = (a < b);

  always_comb
  begin
    case (op)
      cpu_pkg::OP_AND:
        result = a & b;
      cpu_pkg::OP_OR:
        result = a | b;
      cpu_pkg::OP_XOR:
        result = a ^ b;
      cpu_pkg::OP_GT:
        result = cpu_pkg::data_t'(a_gt_b);  // 1 or 0
      cpu_pkg::OP_LT:
        result = cpu_pkg::data_t'(a_lt_b);
      cpu_pkg::OP_MOV:
        result = a;
      default:
        result = '0;  // Former FP ops and unused codes
    endcase
  end

endmodule

/* datapath/reg_bank.sv */
`timescale 1ns/1ps

`include "cpu_defs.svh"

module reg_bank (
  input  logic            clk,
  input  logic            reset,
  input  cpu_pkg::exec_t  exec,
  input  cpu_pkg::data_t  alu_result,
  input  cpu_pkg::data_t  p0,
  input  cpu_pkg::data_t  p1,
  input  logic [1:0]      p_sel,
  output cpu_pkg::data_t  rd_a,
  output cpu_pkg::data_t  rd_b,
  output cpu_pkg::data_t  p0_out,
  output cpu_pkg::data_t  p1_out
);

  cpu_pkg::data_t regs [`CPU_NUM_REGS];
  cpu_pkg::data_t wr_data;
  logic           wr_r0;
  logic           wr_r1;

  assign wr_r0 = (exec.instr.rd == cpu_pkg::reg_idx_t'(0));
  assign wr_r1 = (exec.instr.rd == cpu_pkg::reg_idx_t'(1));

  // Port registers take the external word when their select bit is low
  always_comb
  begin
    wr_data = alu_result;
    if (wr_r0 && !p_sel[0])
      wr_data = p0;
    else if (wr_r1 && !p_sel[1])
      wr_data = p1;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < `CPU_NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (exec.valid)
    begin
      regs[exec.instr.rd] <= wr_data;  // Lands before the next read
    end
  end

  // Combinational reads, no forwarding needed
  assign rd_a = regs[exec.instr.ra];
  assign rd_b = regs[exec.instr.rb];

  assign p0_out = regs[0];
  assign p1_out = regs[1];

endmodule

/* hdl/run_sequencer.sv */
`timescale 1ns/1ps

`include "cpu_defs.svh"

module run_sequencer (
  input  logic  clk,
  input  logic  reset,
  input  logic  run,
  input  logic  last,
  output logic  fetch_en,
  output logic  busy,
  output logic  done
);

  cpu_pkg::seq_state_e state;
  cpu_pkg::seq_state_e state_nxt;

  always_comb
  begin
    state_nxt = state;
    case (state)
      cpu_pkg::IDLE:  if (run) state_nxt = cpu_pkg::RUN;
      cpu_pkg::RUN:   if (last) state_nxt = cpu_pkg::DRAIN;  // Last word fetched here
      cpu_pkg::DRAIN: state_nxt = cpu_pkg::IDLE;             // Final write-back
      default:        state_nxt = cpu_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state <= cpu_pkg::IDLE;
      done  <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      done  <= (state == cpu_pkg::DRAIN);  // One-cycle pulse as busy drops
    end
  end

  assign fetch_en = (state == cpu_pkg::RUN);
  assign busy     = (state != cpu_pkg::IDLE);

  // Host may only start a program while the machine is idle
  a_no_run_while_busy: assert property (
    @(posedge clk) disable iff (reset)
    busy |-> !run
  );

  // Done is seen N+2 edges after run, with N from 1 up to the memory depth
  a_run_finishes: assert property (
    @(posedge clk) disable iff (reset)
    (state == cpu_pkg::IDLE && run) |-> ##[3:`CPU_MEM_DEPTH+2] done
  );

endmodule

/* hdl/program_counter.sv */
`timescale 1ns/1ps

`include "cpu_defs.svh"

module program_counter (
  input  logic          clk,
  input  logic          reset,
  input  logic          load_valid,
  input  logic          fetch_en,
  output cpu_pkg::pc_t  load_addr,
  output cpu_pkg::pc_t  fetch_addr,
  output logic          last
);

  // One bit wider than an address so a full store can be counted
  logic [$clog2(`CPU_MEM_DEPTH):0] load_cnt;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      load_cnt <= '0;
    else if (load_valid)
      load_cnt <= load_cnt + 1'b1;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      fetch_addr <= '0;
    else if (!fetch_en)
      fetch_addr <= '0;  // Parked at 0 ready for the next run
    else
      fetch_addr <= fetch_addr + 1'b1;
  end

  assign load_addr = load_cnt[$clog2(`CPU_MEM_DEPTH)-1:0];

  // Empty program never matches since count-1 wraps to all ones
  assign last = ({1'b0, fetch_addr} == load_cnt - 1'b1);

  a_load_cnt_no_wrap: assert property (
    @(posedge clk) disable iff (reset)
    load_valid |-> (load_cnt < `CPU_MEM_DEPTH)
  );

endmodule

/* hdl/program_mem.sv */
`timescale 1ns/1ps

`include "cpu_defs.svh"

module program_mem (
  input  logic                clk,
  input  logic                reset,
  input  cpu_pkg::load_req_t  load,
  input  cpu_pkg::pc_t        load_addr,
  input  logic                fetch_en,
  input  cpu_pkg::pc_t        fetch_addr,
  input  logic                busy,
  output cpu_pkg::exec_t      exec
);

  logic [`CPU_INSTR_W-1:0] mem [`CPU_MEM_DEPTH];
  cpu_pkg::instr_t         ir;        // Instruction register
  logic                    ir_valid;

  always_ff @(posedge clk)
  begin
    if (load.valid)
      mem[load_addr] <= load.instr;
    if (fetch_en)
      ir <= cpu_pkg::instr_t'(mem[fetch_addr]);
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ir_valid <= 1'b0;
    else
      ir_valid <= fetch_en;  // Valid for exactly the cycle after a fetch
  end

  assign exec = '{valid: ir_valid, instr: ir};

  // Program must not change under a running fetch
  a_no_load_while_busy: assert property (
    @(posedge clk) disable iff (reset)
    busy |-> !load.valid
  );

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
  input  logic                clk,
  input  logic                reset,
  input  cpu_pkg::load_req_t  load,
  input  logic                run,
  input  cpu_pkg::data_t      p0,
  input  cpu_pkg::data_t      p1,
  input  logic [1:0]          p_sel,
  output logic                busy,
  output logic                done,
  output cpu_pkg::data_t      p0_out,
  output cpu_pkg::data_t      p1_out
);

  logic            fetch_en;
  logic            last;
  cpu_pkg::pc_t    load_addr;
  cpu_pkg::pc_t    fetch_addr;
  cpu_pkg::exec_t  exec;     // Instruction in execute
  cpu_pkg::data_t  rd_a;
  cpu_pkg::data_t  rd_b;
  cpu_pkg::data_t  alu_result;

  run_sequencer u_seq (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .last     (last),
    .fetch_en (fetch_en),
    .busy     (busy),
    .done     (done)
  );

  program_counter u_pc (
    .clk        (clk),
    .reset      (reset),
    .load_valid (load.valid),
    .fetch_en   (fetch_en),
    .load_addr  (load_addr),
    .fetch_addr (fetch_addr),
    .last       (last)
  );

  program_mem u_mem (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .load_addr  (load_addr),
    .fetch_en   (fetch_en),
    .fetch_addr (fetch_addr),
    .busy       (busy),
    .exec       (exec)
  );

  reg_bank u_regs (
    .clk        (clk),
    .reset      (reset),
    .exec       (exec),
    .alu_result (alu_result),
    .p0         (p0),
    .p1         (p1),
    .p_sel      (p_sel),
    .rd_a       (rd_a),
    .rd_b       (rd_b),
    .p0_out     (p0_out),
    .p1_out     (p1_out)
  );

  alu u_alu (
    .op     (exec.instr.op),
    .a      (rd_a),
    .b      (rd_b),
    .result (alu_result)
  );

endmodule

/* verif/tb_cpu.sv */
`timescale 1ns/1ps

`include "cpu_defs.svh"

module tb_cpu;

  localparam int NUM_ROWS       = 11;
  localparam int MAX_WORDS      = 8;
  localparam int RESET_CYCLES   = 5;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * (RESET_CYCLES + MAX_WORDS + MAX_WORDS + 10);

  // One table row, a program plus its port setup and expected results
  typedef struct packed {
    cpu_pkg::instr_t [MAX_WORDS-1:0] prog;
    logic [3:0]                      len;
    cpu_pkg::data_t                  p0;
    cpu_pkg::data_t                  p1;
    logic [1:0]                      sel_cap;  // p_sel for the first two writes
    logic [1:0]                      sel_run;  // p_sel from the third write on
    cpu_pkg::data_t                  exp0;
    cpu_pkg::data_t                  exp1;
  } case_t;

  logic               clk = 1'b0;
  logic               reset;
  cpu_pkg::load_req_t load;
  logic               run;
  cpu_pkg::data_t     p0;
  cpu_pkg::data_t     p1;
  logic [1:0]         p_sel;
  logic               busy;
  logic               done;
  cpu_pkg::data_t     p0_out;
  cpu_pkg::data_t     p1_out;

  case_t        cases [NUM_ROWS];
  int           n_rows;
  logic [31:0]  seed;
  int           cycles;

  cpu_top dut (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .run    (run),
    .p0     (p0),
    .p1     (p1),
    .p_sel  (p_sel),
    .busy   (busy),
    .done   (done),
    .p0_out (p0_out),
    .p1_out (p1_out)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $fatal(1, "Simulation stopped by timeout");
    end
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected ALU behavior, compares are unsigned
  function automatic cpu_pkg::data_t alu_model(input logic [3:0] op, input cpu_pkg::data_t a,
                                               input cpu_pkg::data_t b);
    case (op)
      `CPU_OP_AND: return a & b;
      `CPU_OP_OR:  return a | b;
      `CPU_OP_XOR: return a ^ b;
      `CPU_OP_GT:  return (a > b) ? 16'd1 : 16'd0;
      `CPU_OP_LT:  return (a < b) ? 16'd1 : 16'd0;
      `CPU_OP_MOV: return a;
      default:     return 16'd0;
    endcase
  endfunction

  function automatic cpu_pkg::instr_t make_instr(input logic [3:0] op, input logic [2:0] rd,
                                                 input logic [2:0] ra, input logic [2:0] rb);
    cpu_pkg::instr_t w;
    w    = '0;
    w.op = cpu_pkg::opcode_e'(op);
    w.rd = rd;
    w.ra = ra;
    w.rb = rb;
    return w;
  endfunction

  // Capture r0 and r1, compute into r2, copy r2 back to r0
  task automatic add_alu_row(input logic [3:0] op, input cpu_pkg::data_t a,
                             input cpu_pkg::data_t b, input cpu_pkg::data_t exp, input logic rnd);
    case_t c;
    c         = '0;
    c.prog[0] = make_instr(`CPU_OP_MOV, 3'd0, 3'd0, 3'd0);
    c.prog[1] = make_instr(`CPU_OP_MOV, 3'd1, 3'd1, 3'd0);
    c.prog[2] = make_instr(op, 3'd2, 3'd0, 3'd1);
    c.prog[3] = make_instr(`CPU_OP_MOV, 3'd0, 3'd2, 3'd0);
    c.len     = 4'd4;
    c.sel_cap = 2'b00;
    c.sel_run = 2'b11;
    c.p0      = a;
    c.p1      = b;
    c.exp0    = exp;
    if (rnd)
    begin
      seed   = lcg_next(seed);
      c.p0   = seed[31:16];
      seed   = lcg_next(seed);
      c.p1   = seed[31:16];
      c.exp0 = alu_model(op, c.p0, c.p1);
    end
    c.exp1         = c.p1;  // r1 is never rewritten
    cases[n_rows]  = c;
    n_rows         = n_rows + 1;
  endtask

  task automatic build_table();
    case_t c;
    c         = '0;  // Plain port capture
    c.prog[0] = make_instr(`CPU_OP_MOV, 3'd0, 3'd0, 3'd0);
    c.prog[1] = make_instr(`CPU_OP_MOV, 3'd1, 3'd1, 3'd0);
    c.len     = 4'd2;
    c.p0      = 16'hA5C3;
    c.p1      = 16'h5A3C;
    c.exp0    = 16'hA5C3;
    c.exp1    = 16'h5A3C;
    cases[n_rows] = c;
    n_rows        = n_rows + 1;
    add_alu_row(`CPU_OP_AND, 16'hF0F0, 16'h3CC3, 16'h30C0, 1'b0);
    add_alu_row(`CPU_OP_OR,  16'h1234, 16'h0F00, 16'h1F34, 1'b0);
    add_alu_row(`CPU_OP_XOR, 16'hFFFF, 16'h1234, 16'hEDCB, 1'b0);
    add_alu_row(`CPU_OP_GT,  16'h8000, 16'h7FFF, 16'h0001, 1'b0);
    add_alu_row(`CPU_OP_LT,  16'h0001, 16'hFFFE, 16'h0001, 1'b0);
    add_alu_row(4'd2,        16'h1111, 16'h2222, 16'h0000, 1'b0);  // Former FP add
    c         = '0;  // Each result feeds the very next instruction
    c.prog[0] = make_instr(`CPU_OP_MOV, 3'd0, 3'd0, 3'd0);
    c.prog[1] = make_instr(`CPU_OP_MOV, 3'd1, 3'd1, 3'd0);
    c.prog[2] = make_instr(`CPU_OP_XOR, 3'd2, 3'd0, 3'd1);
    c.prog[3] = make_instr(`CPU_OP_AND, 3'd3, 3'd2, 3'd0);
    c.prog[4] = make_instr(`CPU_OP_OR,  3'd4, 3'd3, 3'd1);
    c.prog[5] = make_instr(`CPU_OP_GT,  3'd5, 3'd4, 3'd3);
    c.prog[6] = make_instr(`CPU_OP_MOV, 3'd1, 3'd4, 3'd0);
    c.prog[7] = make_instr(`CPU_OP_MOV, 3'd0, 3'd5, 3'd0);
    c.len     = 4'd8;
    c.sel_run = 2'b11;
    c.p0      = 16'h00FF;
    c.p1      = 16'h0F0F;
    c.exp0    = 16'h0001;
    c.exp1    = 16'h0FFF;
    cases[n_rows] = c;
    n_rows        = n_rows + 1;
    add_alu_row(`CPU_OP_XOR, 16'h0, 16'h0, 16'h0, 1'b1);
    add_alu_row(`CPU_OP_GT,  16'h0, 16'h0, 16'h0, 1'b1);
    add_alu_row(`CPU_OP_LT,  16'h0, 16'h0, 16'h0, 1'b1);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1 reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
  endtask

  task automatic run_case(input int idx);
    case_t c;
    int    cyc;
    c = cases[idx];
    apply_reset();
    check("busy", 32'(busy), 0);
    check("done", 32'(done), 0);
    check("p0_out", 32'(p0_out), 0);
    check("p1_out", 32'(p1_out), 0);
    p0    = c.p0;
    p1    = c.p1;
    p_sel = c.sel_cap;
    for (int i = 0; i < int'(c.len); i++)
    begin
      load.valid = 1'b1;
      load.instr = c.prog[i[2:0]];
      @(posedge clk);
      #1;
    end
    load = '0;
    run  = 1'b1;
    @(posedge clk);  // This edge samples run
    #1 run = 1'b0;
    check("busy", 32'(busy), 1);
    cyc = 0;
    while (done !== 1'b1)
    begin
      @(posedge clk);
      #1;
      cyc = cyc + 1;
      if (cyc == 3)
        p_sel = c.sel_run;  // First two writes already done
    end
    check("done_cycle", 32'(cyc), 32'(int'(c.len) + 1));
    check("busy", 32'(busy), 0);
    check("p0_out", 32'(p0_out), 32'(c.exp0));
    check("p1_out", 32'(p1_out), 32'(c.exp1));
    @(posedge clk);
    #1;
    check("done", 32'(done), 0);
    check("p0_out", 32'(p0_out), 32'(c.exp0));
  endtask

  initial
  begin
    reset  = 1'b1;
    load   = '0;
    run    = 1'b0;
    p0     = '0;
    p1     = '0;
    p_sel  = 2'b00;
    cycles = 0;
    n_rows = 0;
    seed   = 32'h272e_457d;
    build_table();
    for (int r = 0; r < n_rows; r++)
      run_case(r);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* tb.f */
+incdir+common
common/cpu_pkg.sv
datapath/alu.sv
datapath/reg_bank.sv
hdl/run_sequencer.sv
hdl/program_counter.sv
hdl/program_mem.sv
hdl/cpu_top.sv
verif/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the testbench, pass only if the pass line shows up
verilator --binary --timing --assert -f tb.f --top-module tb_cpu \
  && ./obj_dir/Vtb_cpu | grep -F "*** TEST PASSED ***" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
